// ==== rtl/rp_adc_decode.sv ====
//////////////////////////////
// rise and fall bits come already captured
// two cycles from pins to adc_dat_o
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_adc_decode (
  input  logic                   adc_clk_01,
  input  logic                   rst_i,
  input  rp_io_pkg::adc_pins_t   adc_rise_i [`RP_ADC_CH], // odd bits
  input  rp_io_pkg::adc_pins_t   adc_fall_i [`RP_ADC_CH], // even bits
  output rp_io_pkg::adc_sample_t adc_dat_o  [`RP_ADC_CH]
);

  import rp_io_pkg::*;

  adc_sample_t raw   [`RP_ADC_CH]; // reassembled offset code
  adc_sample_t dat_r [`RP_ADC_CH]; // first stage

  // interleave the DDR halves
  always_comb begin
    for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
      for (int k = 0; k < `RP_ADC_PINS; k++) begin
        raw[ch][2*k]   = adc_fall_i[ch][k];
        raw[ch][2*k+1] = adc_rise_i[ch][k];
      end
    end
  end

  // negative slope offset binary to two's complement
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        dat_r[ch]     <= '0;
        adc_dat_o[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        dat_r[ch]     <= {raw[ch][`RP_ADC_DW-1], ~raw[ch][`RP_ADC_DW-2:0]}; // msb kept
        adc_dat_o[ch] <= dat_r[ch];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rp_ams_regs.sv ====
//////////////////////////////
// four PDM settings, 8 bits each, one per word
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_ams_regs (
  input  logic                  adc_clk_01,
  input  logic                  rst_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  rp_bus_pkg::bus_ofs_t  ofs_i,
  input  rp_bus_pkg::bus_data_t wdata_i,
  output rp_bus_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  output rp_io_pkg::pdm_cfg_t   pdm_cfg_o [`RP_PDM_CH]
);

  import rp_bus_pkg::*;

  bus_data_t rd_val;
  logic      hit; // offset names a channel

  always_comb begin
    hit    = 1'b0;
    rd_val = '0;
    for (int ch = 0; ch < `RP_PDM_CH; ch++) begin
      if (ofs_i == bus_ofs_t'(`RP_AMS_PDM_OFS + 4*ch)) begin
        hit    = 1'b1;
        rd_val = bus_data_t'(pdm_cfg_o[ch]);
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      for (int ch = 0; ch < `RP_PDM_CH; ch++)
        pdm_cfg_o[ch] <= '0;
    end else if (wen_i) begin
      for (int ch = 0; ch < `RP_PDM_CH; ch++) begin
        if (ofs_i == bus_ofs_t'(`RP_AMS_PDM_OFS + 4*ch))
          pdm_cfg_o[ch] <= wdata_i[7:0]; // upper bits dropped
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= wen_i || ren_i;
      err_o <= (wen_i || ren_i) && !hit;
    end
  end

  always_ff @(posedge adc_clk_01) begin
    rdata_o <= ren_i ? rd_val : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/rp_bus_decoder.sv ====
//////////////////////////////
// one strobe per request, no back-pressure
// answer two cycles after the strobe
// regions 2 to 7 answer with err
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_bus_decoder (
  input  logic                  adc_clk_01,
  input  logic                  rst_i,
  // master side
  input  rp_bus_pkg::bus_addr_t sys_addr_i,
  input  rp_bus_pkg::bus_data_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output rp_bus_pkg::bus_data_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // region strobes
  output logic                  hk_wen_o,
  output logic                  hk_ren_o,
  output logic                  ams_wen_o,
  output logic                  ams_ren_o,
  output rp_bus_pkg::bus_ofs_t  ofs_o,
  output rp_bus_pkg::bus_data_t wdata_o,
  // region answers, one cycle after strobe
  input  rp_bus_pkg::bus_data_t hk_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  hk_err_i,
  input  rp_bus_pkg::bus_data_t ams_rdata_i,
  input  logic                  ams_ack_i,
  input  logic                  ams_err_i
);

  import rp_bus_pkg::*;

  bus_region_e region;
  logic        none_ack_q; // unmapped access, lined up with a region answer
  logic        ack_m;
  logic        err_m;
  bus_data_t   rdata_m;

  assign region = bus_region_e'(sys_addr_i[`RP_REG_LSB +: `RP_REG_W]);

  assign hk_wen_o  = sys_wen_i && (region == REG_HK);
  assign hk_ren_o  = sys_ren_i && (region == REG_HK);
  assign ams_wen_o = sys_wen_i && (region == REG_AMS);
  assign ams_ren_o = sys_ren_i && (region == REG_AMS);
  assign ofs_o     = sys_addr_i[`RP_REG_LSB-1:0]; // blocks see only the offset
  assign wdata_o   = sys_wdata_i;

  always_ff @(posedge adc_clk_01) begin
    if (rst_i)
      none_ack_q <= 1'b0;
    else
      none_ack_q <= (sys_wen_i || sys_ren_i) && (region != REG_HK) && (region != REG_AMS);
  end

  // at most one answer per cycle
  assign ack_m   = hk_ack_i | ams_ack_i | none_ack_q;
  assign err_m   = hk_err_i | ams_err_i | none_ack_q;
  assign rdata_m = hk_ack_i ? hk_rdata_i : (ams_ack_i ? ams_rdata_i : '0);

  //////////////////////////////
  // response register
  //////////////////////////////
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= ack_m;
      sys_err_o <= err_m;
    end
  end

  always_ff @(posedge adc_clk_01) begin
    sys_rdata_o <= rdata_m;
  end

endmodule

`default_nettype wire

// ==== rtl/rp_bus_pkg.sv ====
//////////////////////////////
// system bus types
// region index sits above the in-region offset
//////////////////////////////
`default_nettype none

`include "rp_cfg.svh"

package rp_bus_pkg;

  typedef logic [`RP_BUS_AW-1:0]  bus_addr_t; // full bus address
  typedef logic [`RP_BUS_DW-1:0]  bus_data_t; // read and write word
  typedef logic [`RP_REG_LSB-1:0] bus_ofs_t;  // offset inside one region

  // region map, only two regions are populated
  typedef enum logic [`RP_REG_W-1:0] {
    REG_HK     = 3'd0, // housekeeping
    REG_AMS    = 3'd1, // analog outputs
    REG_NONE_2 = 3'd2,
    REG_NONE_3 = 3'd3,
    REG_NONE_4 = 3'd4,
    REG_NONE_5 = 3'd5,
    REG_NONE_6 = 3'd6,
    REG_NONE_7 = 3'd7
  } bus_region_e;

endpackage

`default_nettype wire

// ==== rtl/rp_cfg.svh ====
//////////////////////////////
// board widths, register map and ID word
// offsets are byte addresses inside a 4 KB region
//////////////////////////////
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// datapath
`define RP_ADC_CH   4             // ADC channels
`define RP_ADC_DW   14            // bits per sample
`define RP_ADC_PINS 7             // DDR pins per channel
`define RP_EXP_W    11            // expansion pins per side
`define RP_PDM_CH   4
`define RP_PDM_RNG  255           // PDM full scale

// system bus
`define RP_BUS_AW   16
`define RP_BUS_DW   32
`define RP_REG_LSB  12            // region field starts here
`define RP_REG_W    3             // eight regions

`define RP_HK_ID    32'h5250_0401 // housekeeping ID word

// housekeeping offsets
`define RP_HK_ID_OFS   12'h000
`define RP_HK_LED_OFS  12'h004
`define RP_HK_TRIG_OFS 12'h008
`define RP_HK_PDIR_OFS 12'h00C
`define RP_HK_NDIR_OFS 12'h010
`define RP_HK_POUT_OFS 12'h014
`define RP_HK_NOUT_OFS 12'h018
`define RP_HK_PIN_OFS  12'h01C
`define RP_HK_NIN_OFS  12'h020
`define RP_HK_CNT_OFS  12'h030

// analog output, channel n at base + 4*n
`define RP_AMS_PDM_OFS 12'h000

`endif

// ==== rtl/rp_exp_io.sv ====
//////////////////////////////
// pads arrive as separate in, out and enable
// inputs pass a two flop synchronizer
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_exp_io (
  input  logic                 adc_clk_01,
  input  logic                 rst_i,
  input  rp_io_pkg::exp_word_t exp_p_i,   // raw pad inputs
  input  rp_io_pkg::exp_word_t exp_n_i,
  // from housekeeping
  input  rp_io_pkg::exp_word_t exp_p_dir_i,
  input  rp_io_pkg::exp_word_t exp_n_dir_i,
  input  rp_io_pkg::exp_word_t exp_p_out_i,
  input  rp_io_pkg::exp_word_t exp_n_out_i,
  input  logic                 trig_out_en_i,
  input  rp_io_pkg::trig_src_e trig_src_i,
  // triggers from the dropped cores
  input  logic                 scope_trig_i,
  input  logic                 trig_asg_i,
  // pads
  output rp_io_pkg::exp_word_t exp_p_o,
  output rp_io_pkg::exp_word_t exp_p_oe_o,
  output rp_io_pkg::exp_word_t exp_n_o,
  output rp_io_pkg::exp_word_t exp_n_oe_o,
  // readback and external trigger
  output rp_io_pkg::exp_word_t exp_p_in_o,
  output rp_io_pkg::exp_word_t exp_n_in_o,
  output logic                 trig_ext_o
);

  import rp_io_pkg::*;

  exp_word_t p_meta, n_meta; // first sync stage
  logic      trig_sel;

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      p_meta     <= '0;
      n_meta     <= '0;
      exp_p_in_o <= '0;
      exp_n_in_o <= '0;
    end else begin
      p_meta     <= exp_p_i;
      n_meta     <= exp_n_i;
      exp_p_in_o <= p_meta;
      exp_n_in_o <= n_meta;
    end
  end

  assign trig_ext_o = exp_p_in_o[0]; // external trigger on p[0]

  //////////////////////////////
  // n[0] alternate function
  //////////////////////////////
  assign trig_sel = (trig_src_i == TRIG_SRC_ASG) ? trig_asg_i : scope_trig_i;

  assign exp_p_o    = exp_p_out_i;
  assign exp_p_oe_o = exp_p_dir_i;
  assign exp_n_o    = trig_out_en_i ? {exp_n_out_i[`RP_EXP_W-1:1], trig_sel} : exp_n_out_i;
  assign exp_n_oe_o = exp_n_dir_i | exp_word_t'(trig_out_en_i); // forces n[0] out

endmodule

`default_nettype wire

// ==== rtl/rp_hk_regs.sv ====
//////////////////////////////
// ID, inputs and unlock count are read only
// a write to them or an unknown offset gives err
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_hk_regs (
  input  logic                  adc_clk_01,
  input  logic                  rst_i,
  // region bus
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  rp_bus_pkg::bus_ofs_t  ofs_i,
  input  rp_bus_pkg::bus_data_t wdata_i,
  output rp_bus_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  // status
  input  logic                  pll_locked_i,
  input  rp_io_pkg::exp_word_t  exp_p_in_i, // already synchronized
  input  rp_io_pkg::exp_word_t  exp_n_in_i,
  // configuration
  output logic [7:0]            led_o,
  output logic                  trig_out_en_o,
  output rp_io_pkg::trig_src_e  trig_src_o,
  output rp_io_pkg::exp_word_t  exp_p_dir_o, // 1 = output
  output rp_io_pkg::exp_word_t  exp_n_dir_o,
  output rp_io_pkg::exp_word_t  exp_p_out_o,
  output rp_io_pkg::exp_word_t  exp_n_out_o
);

  import rp_bus_pkg::*;
  import rp_io_pkg::*;

  bus_data_t unlock_cnt; // wraps
  bus_data_t rd_val;
  logic      known;
  logic      ro;

  assign ro = (ofs_i == `RP_HK_ID_OFS)  || (ofs_i == `RP_HK_PIN_OFS) ||
              (ofs_i == `RP_HK_NIN_OFS) || (ofs_i == `RP_HK_CNT_OFS);

  // read mux
  always_comb begin
    rd_val = '0;
    known  = 1'b1;
    case (ofs_i)
      `RP_HK_ID_OFS:   rd_val = `RP_HK_ID;
      `RP_HK_LED_OFS:  rd_val = bus_data_t'(led_o);
      `RP_HK_TRIG_OFS: rd_val = bus_data_t'({trig_src_o, trig_out_en_o});
      `RP_HK_PDIR_OFS: rd_val = bus_data_t'(exp_p_dir_o);
      `RP_HK_NDIR_OFS: rd_val = bus_data_t'(exp_n_dir_o);
      `RP_HK_POUT_OFS: rd_val = bus_data_t'(exp_p_out_o);
      `RP_HK_NOUT_OFS: rd_val = bus_data_t'(exp_n_out_o);
      `RP_HK_PIN_OFS:  rd_val = bus_data_t'(exp_p_in_i);
      `RP_HK_NIN_OFS:  rd_val = bus_data_t'(exp_n_in_i);
      `RP_HK_CNT_OFS:  rd_val = unlock_cnt;
      default:         known  = 1'b0;
    endcase
  end

  //////////////////////////////
  // writable registers
  //////////////////////////////
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      led_o         <= '0;
      trig_out_en_o <= 1'b0;
      trig_src_o    <= TRIG_SRC_SCOPE;
      exp_p_dir_o   <= '0; // all pads input
      exp_n_dir_o   <= '0;
      exp_p_out_o   <= '0;
      exp_n_out_o   <= '0;
    end else if (wen_i) begin
      case (ofs_i)
        `RP_HK_LED_OFS:  led_o <= wdata_i[7:0];
        `RP_HK_TRIG_OFS: begin
          trig_out_en_o <= wdata_i[0];
          trig_src_o    <= trig_src_e'(wdata_i[1]);
        end
        `RP_HK_PDIR_OFS: exp_p_dir_o <= wdata_i[`RP_EXP_W-1:0];
        `RP_HK_NDIR_OFS: exp_n_dir_o <= wdata_i[`RP_EXP_W-1:0];
        `RP_HK_POUT_OFS: exp_p_out_o <= wdata_i[`RP_EXP_W-1:0];
        `RP_HK_NOUT_OFS: exp_n_out_o <= wdata_i[`RP_EXP_W-1:0];
        default: ; // read only or unmapped
      endcase
    end
  end

  // cycles spent with the PLL unlocked
  always_ff @(posedge adc_clk_01) begin
    if (rst_i)
      unlock_cnt <= '0;
    else if (!pll_locked_i)
      unlock_cnt <= unlock_cnt + 1'b1;
  end

  // answer one cycle after the strobe
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= wen_i || ren_i;
      err_o <= (wen_i || ren_i) && (!known || (wen_i && ro));
    end
  end

  always_ff @(posedge adc_clk_01) begin
    rdata_o <= ren_i ? rd_val : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/rp_io_pkg.sv ====
//////////////////////////////
// ADC, PDM and expansion connector types
//////////////////////////////
`default_nettype none

`include "rp_cfg.svh"

package rp_io_pkg;

  // ADC
  typedef logic signed [`RP_ADC_DW-1:0] adc_sample_t; // two's complement sample
  typedef logic [`RP_ADC_PINS-1:0]      adc_pins_t;   // pins captured on one edge

  // analog outputs
  typedef logic [7:0] pdm_cfg_t; // density, 0 to 255

  // expansion connector, one side
  typedef logic [`RP_EXP_W-1:0] exp_word_t;

  // source of the trigger driven out on n[0]
  typedef enum logic {
    TRIG_SRC_SCOPE = 1'b0,
    TRIG_SRC_ASG   = 1'b1
  } trig_src_e;

endpackage

`default_nettype wire

// ==== rtl/rp_pdm.sv ====
//////////////////////////////
// first order PDM, range fixed at 255
// setting n gives n ones in any 255 cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_pdm (
  input  logic                   adc_clk_01,
  input  logic                   rst_i,
  input  rp_io_pkg::pdm_cfg_t    pdm_cfg_i [`RP_PDM_CH],
  output logic [`RP_PDM_CH-1:0]  pdm_o
);

  logic [7:0] acc_q [`RP_PDM_CH]; // always below the range
  logic [8:0] sum   [`RP_PDM_CH];

  always_comb begin
    for (int ch = 0; ch < `RP_PDM_CH; ch++)
      sum[ch] = {1'b0, acc_q[ch]} + {1'b0, pdm_cfg_i[ch]};
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      pdm_o <= '0;
      for (int ch = 0; ch < `RP_PDM_CH; ch++)
        acc_q[ch] <= '0;
    end else begin
      for (int ch = 0; ch < `RP_PDM_CH; ch++) begin
        if (sum[ch] >= `RP_PDM_RNG) begin // overflow, emit a one
          acc_q[ch] <= 8'(sum[ch] - `RP_PDM_RNG);
          pdm_o[ch] <= 1'b1;
        end else begin
          acc_q[ch] <= sum[ch][7:0];
          pdm_o[ch] <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rp_top.sv ====
//////////////////////////////
// fabric housekeeping of the 4 channel board
// single clock, no PS, scope or ASG inside
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_top (
  input  logic                   adc_clk_01,
  input  logic                   rst_i,
  // ADC, captured DDR halves
  input  rp_io_pkg::adc_pins_t   adc_rise_i [`RP_ADC_CH],
  input  rp_io_pkg::adc_pins_t   adc_fall_i [`RP_ADC_CH],
  output rp_io_pkg::adc_sample_t adc_dat_o  [`RP_ADC_CH],
  // system bus
  input  rp_bus_pkg::bus_addr_t  sys_addr_i,
  input  rp_bus_pkg::bus_data_t  sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output rp_bus_pkg::bus_data_t  sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  // misc
  input  logic                   pll_locked_i,
  output logic [7:0]             led_o,
  output logic [`RP_PDM_CH-1:0]  pdm_o,
  input  logic                   scope_trig_i,
  input  logic                   trig_asg_i,
  output logic                   trig_ext_o,
  // expansion connector
  input  rp_io_pkg::exp_word_t   exp_p_i,
  input  rp_io_pkg::exp_word_t   exp_n_i,
  output rp_io_pkg::exp_word_t   exp_p_o,
  output rp_io_pkg::exp_word_t   exp_p_oe_o,
  output rp_io_pkg::exp_word_t   exp_n_o,
  output rp_io_pkg::exp_word_t   exp_n_oe_o
);

  import rp_bus_pkg::*;
  import rp_io_pkg::*;

  // region bus
  logic      hk_wen, hk_ren, ams_wen, ams_ren;
  bus_ofs_t  ofs;
  bus_data_t wdata;
  bus_data_t hk_rdata, ams_rdata;
  logic      hk_ack, hk_err, ams_ack, ams_err;

  // housekeeping to pads
  exp_word_t exp_p_dir, exp_n_dir, exp_p_out, exp_n_out;
  exp_word_t exp_p_in, exp_n_in;
  logic      trig_out_en;
  trig_src_e trig_src;

  pdm_cfg_t  pdm_cfg [`RP_PDM_CH];

  rp_adc_decode adc_decode (
    .adc_clk_01 (adc_clk_01), .rst_i (rst_i),
    .adc_rise_i (adc_rise_i), .adc_fall_i (adc_fall_i), .adc_dat_o (adc_dat_o)
  );

  rp_bus_decoder bus_decoder (
    .adc_clk_01  (adc_clk_01),  .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o), .sys_err_o (sys_err_o),
    .hk_wen_o    (hk_wen),      .hk_ren_o    (hk_ren),
    .ams_wen_o   (ams_wen),     .ams_ren_o   (ams_ren),
    .ofs_o       (ofs),         .wdata_o     (wdata),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i    (hk_ack),    .hk_err_i  (hk_err),
    .ams_rdata_i (ams_rdata),   .ams_ack_i   (ams_ack),   .ams_err_i (ams_err)
  );

  rp_hk_regs hk_regs (
    .adc_clk_01    (adc_clk_01),   .rst_i        (rst_i),
    .wen_i         (hk_wen),       .ren_i        (hk_ren),
    .ofs_i         (ofs),          .wdata_i      (wdata),
    .rdata_o       (hk_rdata),     .ack_o        (hk_ack),    .err_o (hk_err),
    .pll_locked_i  (pll_locked_i),
    .exp_p_in_i    (exp_p_in),     .exp_n_in_i   (exp_n_in),
    .led_o         (led_o),
    .trig_out_en_o (trig_out_en),  .trig_src_o   (trig_src),
    .exp_p_dir_o   (exp_p_dir),    .exp_n_dir_o  (exp_n_dir),
    .exp_p_out_o   (exp_p_out),    .exp_n_out_o  (exp_n_out)
  );

  rp_ams_regs ams_regs (
    .adc_clk_01 (adc_clk_01), .rst_i   (rst_i),
    .wen_i      (ams_wen),    .ren_i   (ams_ren),
    .ofs_i      (ofs),        .wdata_i (wdata),
    .rdata_o    (ams_rdata),  .ack_o   (ams_ack), .err_o (ams_err),
    .pdm_cfg_o  (pdm_cfg)
  );

  rp_pdm pdm (
    .adc_clk_01 (adc_clk_01), .rst_i (rst_i),
    .pdm_cfg_i  (pdm_cfg),    .pdm_o (pdm_o)
  );

  rp_exp_io exp_io (
    .adc_clk_01    (adc_clk_01),   .rst_i       (rst_i),
    .exp_p_i       (exp_p_i),      .exp_n_i     (exp_n_i),
    .exp_p_dir_i   (exp_p_dir),    .exp_n_dir_i (exp_n_dir),
    .exp_p_out_i   (exp_p_out),    .exp_n_out_i (exp_n_out),
    .trig_out_en_i (trig_out_en),  .trig_src_i  (trig_src),
    .scope_trig_i  (scope_trig_i), .trig_asg_i  (trig_asg_i),
    .exp_p_o       (exp_p_o),      .exp_p_oe_o  (exp_p_oe_o),
    .exp_n_o       (exp_n_o),      .exp_n_oe_o  (exp_n_oe_o),
    .exp_p_in_o    (exp_p_in),     .exp_n_in_o  (exp_n_in),
    .trig_ext_o    (trig_ext_o)
  );

endmodule

`default_nettype wire

// ==== test/rp_checker.sv ====
//////////////////////////////
// bus protocol properties, bound to rp_top
// fail_cnt counts failed assertions for the testbench
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rp_checker (
  input logic adc_clk_01,
  input logic rst_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i
);

  int unsigned fail_cnt = 0;

  // one request kind per strobe
  a_one_strobe: assert property (@(posedge adc_clk_01) disable iff (rst_i)
    !(wen_i && ren_i))
    else begin
      $error("write and read strobe in the same cycle");
      fail_cnt++;
    end

  // answer exactly two cycles later
  a_ack_slot: assert property (@(posedge adc_clk_01) disable iff (rst_i)
    (wen_i || ren_i) |-> ##2 ack_i)
    else begin
      $error("no ack two cycles after strobe");
      fail_cnt++;
    end

  a_ack_cause: assert property (@(posedge adc_clk_01) disable iff (rst_i)
    ack_i |-> $past(wen_i || ren_i, 2))
    else begin
      $error("ack without a strobe two cycles before");
      fail_cnt++;
    end

  a_err_ack: assert property (@(posedge adc_clk_01) disable iff (rst_i)
    err_i |-> ack_i)
    else begin
      $error("err outside an ack cycle");
      fail_cnt++;
    end

endmodule

bind rp_top rp_checker bus_chk (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i),
  .wen_i      (sys_wen_i),
  .ren_i      (sys_ren_i),
  .ack_i      (sys_ack_o),
  .err_i      (sys_err_o)
);

`default_nettype wire

// ==== test/rp_tb.sv ====
//////////////////////////////
// directed tests of rp_top, stops at the first mismatch
// inputs change 1 ns after the rising edge, outputs read there too
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_tb;

  import rp_bus_pkg::*;
  import rp_io_pkg::*;

  localparam int ACK_TIMEOUT = 8;  // cycles to wait for ack
  localparam int SYNC_LIMIT  = 3;  // pad to readback latency bound

  logic                  adc_clk_01;
  logic                  rst_i;
  adc_pins_t             adc_rise_i [`RP_ADC_CH];
  adc_pins_t             adc_fall_i [`RP_ADC_CH];
  adc_sample_t           adc_dat_o  [`RP_ADC_CH];
  bus_addr_t             sys_addr_i;
  bus_data_t             sys_wdata_i;
  logic                  sys_wen_i;
  logic                  sys_ren_i;
  bus_data_t             sys_rdata_o;
  logic                  sys_ack_o;
  logic                  sys_err_o;
  logic                  pll_locked_i;
  logic [7:0]            led_o;
  logic [`RP_PDM_CH-1:0] pdm_o;
  logic                  scope_trig_i;
  logic                  trig_asg_i;
  logic                  trig_ext_o;
  exp_word_t             exp_p_i, exp_n_i;
  exp_word_t             exp_p_o, exp_p_oe_o, exp_n_o, exp_n_oe_o;

  rp_top dut (.*);

  initial adc_clk_01 = 1'b0;
  always #50 adc_clk_01 = ~adc_clk_01; // 100 ns period

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic step();
    @(posedge adc_clk_01);
    #1;
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input bus_data_t got, input bus_data_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %08h expected %08h", $time, what, got, exp));
  endtask

  task automatic check_sample(input adc_sample_t got, input adc_sample_t exp,
                              input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %04h expected %04h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  function automatic bus_addr_t reg_addr(input int region, input bus_ofs_t ofs);
    bus_addr_t a;
    a = '0;
    a[`RP_REG_LSB +: `RP_REG_W] = region[`RP_REG_W-1:0];
    a[`RP_REG_LSB-1:0]          = ofs;
    return a;
  endfunction

  // even bits from fall, odd from rise, then offset code to two's complement
  function automatic adc_sample_t adc_expect(input adc_pins_t rise, input adc_pins_t fall);
    logic [`RP_ADC_DW-1:0] raw;
    for (int k = 0; k < `RP_ADC_PINS; k++) begin
      raw[2*k]   = fall[k];
      raw[2*k+1] = rise[k];
    end
    return adc_sample_t'(raw ^ {1'b0, {(`RP_ADC_DW-1){1'b1}}});
  endfunction

  //////////////////////////////
  // bus access, one strobe then wait for ack
  //////////////////////////////
  task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata, input logic write,
                            output bus_data_t rdata, output logic err);
    int cycles;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = write;
    sys_ren_i   = !write;
    step();                 // strobe taken on this edge
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    cycles    = 1;
    while (!sys_ack_o && cycles < ACK_TIMEOUT) begin
      step();
      cycles++;
    end
    if (!sys_ack_o)
      fail_run($sformatf("no bus ack within %0d cycles for address %04h", ACK_TIMEOUT, addr));
    check_data(bus_data_t'(cycles), 32'd2, "ack latency");
    rdata = sys_rdata_o;
    err   = sys_err_o;
    if (dut.bus_chk.fail_cnt != 0)
      fail_run("a bus protocol assertion failed");
  endtask

  task automatic write_ok(input bus_addr_t addr, input bus_data_t data);
    bus_data_t rd;
    logic      err;
    bus_access(addr, data, 1'b1, rd, err);
    check_bit(err, 1'b0, $sformatf("err on write to %04h", addr));
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_data_t exp, input string what);
    bus_data_t rd;
    logic      err;
    bus_access(addr, '0, 1'b0, rd, err);
    check_bit(err, 1'b0, {what, " err"});
    check_data(rd, exp, what);
  endtask

  task automatic expect_err(input bus_addr_t addr, input logic write, input string what);
    bus_data_t rd;
    logic      err;
    bus_access(addr, 32'hFFFF_FFFF, write, rd, err);
    check_bit(err, 1'b1, what);
    check_data(rd, '0, {what, " rdata"});
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_values();
    check_bit(sys_ack_o, 1'b0, "ack after reset");
    check_bit(sys_err_o, 1'b0, "err after reset");
    check_data(bus_data_t'(led_o), '0, "led after reset");
    check_data(bus_data_t'(exp_p_oe_o), '0, "p oe after reset");
    check_data(bus_data_t'(exp_n_oe_o), '0, "n oe after reset");
    check_data(bus_data_t'(pdm_o), '0, "pdm after reset");
  endtask

  task automatic reg_roundtrip();
    bus_data_t val;
    bus_ofs_t  ofs [4];
    ofs = '{`RP_HK_PDIR_OFS, `RP_HK_NDIR_OFS, `RP_HK_POUT_OFS, `RP_HK_NOUT_OFS};
    read_check(reg_addr(0, `RP_HK_ID_OFS), `RP_HK_ID, "id");
    write_ok(reg_addr(0, `RP_HK_LED_OFS), 32'h0000_00A5);
    read_check(reg_addr(0, `RP_HK_LED_OFS), 32'h0000_00A5, "led readback");
    check_data(bus_data_t'(led_o), 32'h0000_00A5, "led pins");
    for (int i = 0; i < 4; i++) begin
      val = bus_data_t'(exp_word_t'($urandom));
      write_ok(reg_addr(0, ofs[i]), val);
      read_check(reg_addr(0, ofs[i]), val, $sformatf("hk reg %03h", ofs[i]));
    end
    for (int ch = 0; ch < `RP_PDM_CH; ch++) begin
      val = $urandom;                                       // upper bits are dropped
      write_ok(reg_addr(1, bus_ofs_t'(4*ch)), val);
      read_check(reg_addr(1, bus_ofs_t'(4*ch)), {24'h0, val[7:0]}, $sformatf("pdm %0d", ch));
    end
    // error paths
    expect_err(reg_addr(0, 12'h024), 1'b0, "unknown hk offset");
    expect_err(reg_addr(0, `RP_HK_ID_OFS), 1'b1, "write to id");
    expect_err(reg_addr(0, `RP_HK_PIN_OFS), 1'b1, "write to p input");
    expect_err(reg_addr(1, 12'h010), 1'b0, "unknown ams offset");
    read_check(reg_addr(0, `RP_HK_ID_OFS), `RP_HK_ID, "id after write attempt");
    for (int r = 2; r < 8; r++) begin
      expect_err(reg_addr(r, 12'h000), 1'b0, $sformatf("read region %0d", r));
      expect_err(reg_addr(r, 12'h004), 1'b1, $sformatf("write region %0d", r));
    end
  endtask

  task automatic adc_samples();
    adc_sample_t exp [`RP_ADC_CH];
    for (int n = 0; n < 16; n++) begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        adc_rise_i[ch] = adc_pins_t'($urandom);
        adc_fall_i[ch] = adc_pins_t'($urandom);
        exp[ch]        = adc_expect(adc_rise_i[ch], adc_fall_i[ch]);
      end
      repeat (2) step();    // fixed two stage latency
      for (int ch = 0; ch < `RP_ADC_CH; ch++)
        check_sample(adc_dat_o[ch], exp[ch], $sformatf("adc ch%0d sample %0d", ch, n));
    end
  endtask

  task automatic pdm_density();
    pdm_cfg_t lvl [4];
    pdm_cfg_t cfg [`RP_PDM_CH];
    int       ones [`RP_PDM_CH];
    lvl = '{8'd0, 8'd1, 8'd128, 8'd255};
    for (int i = 0; i < 4; i++) begin
      for (int ch = 0; ch < `RP_PDM_CH; ch++) begin
        cfg[ch] = lvl[(i + ch) % 4];    // each channel a different level
        write_ok(reg_addr(1, bus_ofs_t'(4*ch)), bus_data_t'(cfg[ch]));
      end
      repeat (2) step();                // settle
      for (int ch = 0; ch < `RP_PDM_CH; ch++)
        ones[ch] = 0;
      repeat (`RP_PDM_RNG) begin
        step();
        for (int ch = 0; ch < `RP_PDM_CH; ch++)
          ones[ch] += pdm_o[ch];
      end
      for (int ch = 0; ch < `RP_PDM_CH; ch++)
        check_data(bus_data_t'(ones[ch]), bus_data_t'(cfg[ch]),
                   $sformatf("pdm ch%0d ones in %0d cycles", ch, `RP_PDM_RNG));
    end
  endtask

  task automatic wait_trig_ext(input logic level);
    int cycles;
    cycles = 0;
    while (trig_ext_o !== level && cycles < SYNC_LIMIT) begin
      step();
      cycles++;
    end
    if (trig_ext_o !== level)
      fail_run($sformatf("trig_ext_o did not follow p[0]=%b within %0d cycles",
                         level, SYNC_LIMIT));
  endtask

  task automatic exp_pads();
    exp_word_t pdir, ndir, pout, nout, p_in, n_in;
    pdir = exp_word_t'($urandom);
    ndir = exp_word_t'($urandom);
    pout = exp_word_t'($urandom);
    nout = exp_word_t'($urandom);
    write_ok(reg_addr(0, `RP_HK_PDIR_OFS), bus_data_t'(pdir));
    write_ok(reg_addr(0, `RP_HK_NDIR_OFS), bus_data_t'(ndir));
    write_ok(reg_addr(0, `RP_HK_POUT_OFS), bus_data_t'(pout));
    write_ok(reg_addr(0, `RP_HK_NOUT_OFS), bus_data_t'(nout));
    check_data(bus_data_t'(exp_p_oe_o), bus_data_t'(pdir), "p oe");
    check_data(bus_data_t'(exp_p_o), bus_data_t'(pout), "p out");
    check_data(bus_data_t'(exp_n_oe_o), bus_data_t'(ndir), "n oe");
    check_data(bus_data_t'(exp_n_o), bus_data_t'(nout), "n out");
    // trigger out on n[0], scope source then ASG source
    write_ok(reg_addr(0, `RP_HK_TRIG_OFS), 32'h1);
    read_check(reg_addr(0, `RP_HK_TRIG_OFS), 32'h1, "trig cfg");
    check_data(bus_data_t'(exp_n_oe_o), bus_data_t'(ndir | 11'h1), "n oe with trig");
    scope_trig_i = 1'b1;
    trig_asg_i   = 1'b0;
    step();
    check_bit(exp_n_o[0], 1'b1, "n[0] scope trig high");
    check_data(bus_data_t'(exp_n_o[`RP_EXP_W-1:1]), bus_data_t'(nout[`RP_EXP_W-1:1]),
               "n upper bits with trig");
    scope_trig_i = 1'b0;
    trig_asg_i   = 1'b1;
    step();
    check_bit(exp_n_o[0], 1'b0, "n[0] scope trig low");
    write_ok(reg_addr(0, `RP_HK_TRIG_OFS), 32'h3);
    check_bit(exp_n_o[0], 1'b1, "n[0] asg trig high");
    trig_asg_i = 1'b0;
    step();
    check_bit(exp_n_o[0], 1'b0, "n[0] asg trig low");
    write_ok(reg_addr(0, `RP_HK_TRIG_OFS), 32'h0);
    check_data(bus_data_t'(exp_n_oe_o), bus_data_t'(ndir), "n oe trig off");
    // input readback and external trigger
    p_in    = exp_word_t'($urandom) | 11'h1;
    n_in    = exp_word_t'($urandom);
    exp_p_i = p_in;
    exp_n_i = n_in;
    wait_trig_ext(1'b1);
    read_check(reg_addr(0, `RP_HK_PIN_OFS), bus_data_t'(p_in), "p input readback");
    read_check(reg_addr(0, `RP_HK_NIN_OFS), bus_data_t'(n_in), "n input readback");
    exp_p_i[0] = 1'b0;
    wait_trig_ext(1'b0);
  endtask

  task automatic unlock_count();
    int k;
    k = 5 + ($urandom % 16);
    read_check(reg_addr(0, `RP_HK_CNT_OFS), '0, "unlock count while locked");
    pll_locked_i = 1'b0;
    repeat (k) step();      // k edges see the PLL unlocked
    pll_locked_i = 1'b1;
    read_check(reg_addr(0, `RP_HK_CNT_OFS), bus_data_t'(k), "unlock count");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    rst_i        = 1'b1;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    pll_locked_i = 1'b1;
    scope_trig_i = 1'b0;
    trig_asg_i   = 1'b0;
    exp_p_i      = '0;
    exp_n_i      = '0;
    for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
      adc_rise_i[ch] = '0;
      adc_fall_i[ch] = '0;
    end
    void'($urandom(32'hc7825d20));
    repeat (5) step();
    rst_i = 1'b0;
    reset_values();
    reg_roundtrip();
    adc_samples();
    pdm_density();
    exp_pads();
    unlock_count();
    step();
    if (dut.bus_chk.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "bus protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/rp_bus_pkg.sv
rtl/rp_io_pkg.sv
rtl/rp_adc_decode.sv
rtl/rp_bus_decoder.sv
rtl/rp_hk_regs.sv
rtl/rp_ams_regs.sv
rtl/rp_pdm.sv
rtl/rp_exp_io.sv
rtl/rp_top.sv
test/rp_checker.sv
test/rp_tb.sv
